// ==== sim.f ====
+incdir+dv
verilog/fcuCfgPkg.sv
verilog/fcuIsaPkg.sv
verilog/fcuReqIf.sv
verilog/fcuDispatch.sv
verilog/fcuCalc.sv
verilog/fcuLane.sv
verilog/fcuCollect.sv
verilog/fcuCluster.sv
dv/fcuCluster_properties.sv
dv/fcuClusterTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the flow-control cluster regression with Verilator.
# Exits non-zero on a build error, a simulator error or a failed regression.

set -u
cd "$(dirname "$0")" || exit 1

logFile=sim.log
objDir=obj_dir

verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module fcuClusterTb -Mdir "$objDir" -o fcuClusterSim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"./$objDir/fcuClusterSim" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "Regression failed" "$logFile"; then
  exit 1
fi
if ! grep -q "Regression passed" "$logFile"; then
  echo "No pass line found in $logFile"
  exit 1
fi
exit 0

// ==== dv/fcuModel.svh ====
// Reference model of the flow-control result rule.
// Included inside the testbench module; works on 64-bit data, 32-bit PCs.
`ifndef FCU_MODEL_SVH
`define FCU_MODEL_SVH

function automatic logic [63:0] expectedResult(
  input logic [47:0] instr,
  input logic [63:0] a,
  input logic [31:0] pc,
  input logic [1:0]  level,
  input logic [3:0]  mask,
  input logic [63:0] trapVec,
  input logic [63:0] waitCount
);
  logic [63:0] poison;
  logic [31:0] link;
  logic [3:0]  thresh;
  logic [63:0] offset;
  logic [63:0] result;
  poison = {8{8'hCC}};
  // Address of the following instruction, wraps at 32 bits
  link = pc + 32'd6;
  // Inverse of level with two zero bits below it
  thresh = ~{level, 2'b00};
  // Return offset in words, long form only for size 01
  if (instr[7:6] == 2'b01)
    offset = {36'd0, instr[47:23], 3'b000};
  else
    offset = {52'd0, instr[31:23], 3'b000};
  case (instr[3:0])
    // Break code source select
    4'd0: result = instr[16] ? {56'd0, a[7:0]} : {56'd0, instr[15:8]};
    4'd1:
      if (instr[20:19] == 2'd0)
        result = a + 64'd1;
      else if (instr[20:19] == 2'd1)
        result = a - 64'd1;
      else
        result = poison;
    4'd2, 4'd3: result = {32'd0, link};
    4'd4: result = a + offset;
    4'd5:
      if (level == 2'd0)
        result = poison;
      else
        result = (mask < thresh) ? trapVec : {32'd0, link};
    // Only WAIT is defined
    4'd6:
      if (instr[27:23] == 5'd1)
        result = (waitCount == 64'd1) ? 64'd1 : 64'd0;
      else
        result = poison;
    default: result = poison;
  endcase
  return result;
endfunction

`endif

// ==== dv/fcuClusterTb.sv ====
// Self-checking testbench for the flow-control cluster.
// A flow phase with continuous input checks one-cycle latency, then a
// random phase with gaps and output stalls checks ordering and flow control.
module fcuClusterTb
  import fcuIsaPkg::*;
();

  localparam int numLanes   = 4;
  localparam int numOps     = 500;
  // Operations sent back-to-back with outReady held high
  localparam int numFlow    = 40;
  localparam int cycleLimit = 4 * numOps + 200;

  logic        clk;
  logic        rstN;
  logic        inValid;
  logic        inReady;
  logic [47:0] inInstr;
  logic [63:0] inA;
  logic [31:0] inPc;
  opLevelE     ol;
  logic [3:0]  im;
  logic [63:0] tvec;
  logic [63:0] waitCtr;
  logic        outValid;
  logic        outReady;
  logic [63:0] outBus;

  // Scoreboard, expected results and their input sample cycle
  logic [63:0] expQ [$];
  int          cycQ [$];
  int          numSent    = 0;
  int          numDone    = 0;
  int          errCount   = 0;
  int          checkCount = 0;
  int          cycleCount = 0;
  logic        inTaken    = 1'b0;
  logic [31:0] lcgState   = 32'h73a99579;

  `include "fcuModel.svh"

  fcuCluster #(
    .dataWid  (64),
    .addrMsb  (31),
    .numLanes (numLanes)
  ) dut_i (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .inReady  (inReady),
    .inInstr  (inInstr),
    .inA      (inA),
    .inPc     (inPc),
    .ol       (ol),
    .im       (im),
    .tvec     (tvec),
    .waitCtr  (waitCtr),
    .outValid (outValid),
    .outReady (outReady),
    .outBus   (outBus)
  );

  // ========================================
  // Clock and timeout
  // ========================================

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit)
    begin
      $display("Timeout after %0d cycles with %0d results still pending",
               cycleCount, expQ.size());
      $display("Regression failed");
      $finish;
    end
  end

  // ========================================
  // Helpers
  // ========================================

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  task automatic checkValue(input string name, input logic [63:0] expVal,
                            input logic [63:0] actVal);
    checkCount++;
    if (expVal !== actVal)
    begin
      errCount++;
      $display("ERROR %s expected %h actual %h", name, expVal, actVal);
    end
  endtask

  // Machine state changes freely, the model samples it per transfer
  task automatic driveState();
    logic [31:0] r;
    r = nextRand();
    ol   <= opLevelE'(r[17:16]);
    im   <= r[23:20];
    tvec <= {nextRand(), nextRand()};
    // Mostly 0, 1 or 2 so the WAIT test hits both outcomes
    if (r[31:30] != 2'b11)
      waitCtr <= 64'(r[27:24] % 4'd3);
    else
      waitCtr <= {nextRand(), nextRand()};
  endtask

  task automatic makeOp();
    logic [31:0] r;
    logic [31:0] hi;
    logic [31:0] lo;
    logic [47:0] word;
    r  = nextRand();
    hi = nextRand();
    lo = nextRand();
    word = {hi[15:0], lo};
    // About 13 in 16 legal opcodes
    if (r[31:28] < 4'd13)
      word[3:0] = r[19:16] % 4'd7;
    else
      word[3:0] = 4'd7 + (r[23:20] % 4'd9);
    if (r[8])
      word[27:23] = 5'd1;
    if (r[9])
      word[7:6] = 2'b01;
    if (r[10])
      word[20] = 1'b0;
    inInstr <= word;
    // Edge operands for counter wraparound
    case (r[13:12])
      2'd0:    inA <= 64'd0;
      2'd1:    inA <= '1;
      default: inA <= {nextRand(), nextRand()};
    endcase
    // Some PCs near the top of the address space
    if (r[15:14] == 2'b11)
      inPc <= {29'h1FFF_FFFF, r[2:0]};
    else
      inPc <= nextRand();
  endtask

  // Rising-edge drive, holds a pending request until it transfers
  task automatic driveCycle();
    logic [31:0] r;
    r = nextRand();
    driveState();
    if (!inValid || inTaken)
    begin
      if (numSent < numOps && (numSent < numFlow || r[31:30] != 2'b00))
      begin
        makeOp();
        inValid <= 1'b1;
        numSent++;
      end
      else
        inValid <= 1'b0;
    end
    if (numDone < numFlow)
      outReady <= 1'b1;
    else
      outReady <= (r[29:28] != 2'b00);
  endtask

  // Falling-edge sample, decides the transfers of the next rising edge
  task automatic sampleCycle();
    logic [63:0] expVal;
    int          inCyc;
    int          occupied;
    occupied = expQ.size();
    // Full lanes stall input only when the oldest result is stalled too
    checkValue("inReady", {63'd0, (occupied < numLanes) || outReady}, {63'd0, inReady});
    checkValue("outValid", {63'd0, occupied > 0}, {63'd0, outValid});
    inTaken = inValid && inReady;
    if (outValid && outReady)
    begin
      if (occupied == 0)
      begin
        errCount++;
        $display("Output transfer at cycle %0d with no result pending", cycleCount);
      end
      else
      begin
        expVal = expQ.pop_front();
        inCyc  = cycQ.pop_front();
        checkValue("outBus", expVal, outBus);
        if (numDone < numFlow)
          checkValue("outValid latency", 64'd1, 64'(cycleCount - inCyc));
      end
      numDone++;
    end
    if (inTaken)
    begin
      expQ.push_back(expectedResult(inInstr, inA, inPc, ol, im, tvec, waitCtr));
      cycQ.push_back(cycleCount);
    end
  endtask

  // ========================================
  // Main sequence
  // ========================================

  initial
  begin
    rstN     = 1'b0;
    inValid  = 1'b0;
    inInstr  = '0;
    inA      = '0;
    inPc     = '0;
    ol       = USER;
    im       = '0;
    tvec     = '0;
    waitCtr  = '0;
    outReady = 1'b0;
    repeat (2) @(posedge clk);
    rstN <= 1'b1;
    // Idle state before the first request
    @(negedge clk);
    checkValue("outValid", 64'd0, {63'd0, outValid});
    checkValue("inReady", 64'd1, {63'd0, inReady});
    while (numDone < numOps)
    begin
      @(posedge clk);
      driveCycle();
      @(negedge clk);
      sampleCycle();
    end
    // Every accepted request must have produced its result
    if (expQ.size() != 0)
    begin
      errCount++;
      $display("%0d results still pending at the end of the run", expQ.size());
    end
    $display("Checks %0d, errors %0d", checkCount, errCount);
    if (errCount == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

// ==== dv/fcuCluster_properties.sv ====
// Concurrent checks on the cluster output handshake.
// Bound into fcuCluster by the bind statement below.
module fcuClusterProperties #(
  parameter int numLanes = 4,
  parameter int dataWid  = 64
) (
  input logic                clk,
  input logic                rstN,
  input logic                outValid,
  input logic                outReady,
  input logic [dataWid-1:0]  outBus,
  input logic [numLanes-1:0] rspValid
);

  // Stalled result holds valid and data
  stallHold: assert property (@(posedge clk) disable iff (!rstN)
    outValid && !outReady |=> outValid && $stable(outBus))
    else $error("Output changed while stalled");

  resetIdle: assert property (@(posedge clk) !rstN |-> !outValid)
    else $error("Output valid during reset");

  // A lane gives up its result only on an output transfer
  laneRelease: assert property (@(posedge clk) disable iff (!rstN)
    !(outValid && outReady) |=> (rspValid & $past(rspValid)) == $past(rspValid))
    else $error("Lane result dropped without output transfer");

endmodule

bind fcuCluster fcuClusterProperties #(
  .numLanes (numLanes),
  .dataWid  (dataWid)
) props_i (
  .clk      (clk),
  .rstN     (rstN),
  .outValid (outValid),
  .outReady (outReady),
  .outBus   (outBus),
  .rspValid (rspValid)
);

// ==== verilog/fcuCluster.sv ====
// Top level of the flow-control calculation cluster.
// Requests are spread round-robin over numLanes lanes and the results are
// drained back in issue order. All handshakes follow valid/ready rules.
module fcuCluster
  import fcuCfgPkg::*, fcuIsaPkg::*;
#(
  parameter int dataWid  = 64,
  parameter int addrMsb  = 31,
  parameter int numLanes = 4
) (
  input  logic                clk,
  input  logic                rstN,
  // Request handshake
  input  logic                inValid,
  output logic                inReady,
  input  logic [instrWid-1:0] inInstr,
  input  logic [dataWid-1:0]  inA,
  input  logic [addrMsb:0]    inPc,
  // Machine state
  input  opLevelE             ol,
  input  logic [3:0]          im,
  input  logic [dataWid-1:0]  tvec,
  input  logic [dataWid-1:0]  waitCtr,
  // Response handshake
  output logic                outValid,
  input  logic                outReady,
  output logic [dataWid-1:0]  outBus
);

  logic [numLanes-1:0]              rspValid;
  logic [numLanes-1:0]              rspReady;
  logic [numLanes-1:0][dataWid-1:0] rspBus;

  // One request link per lane
  fcuReqIf #(.dataWid(dataWid), .addrMsb(addrMsb)) laneReq [numLanes] ();

  fcuDispatch #(
    .numLanes (numLanes),
    .dataWid  (dataWid),
    .addrMsb  (addrMsb)
  ) dispatch_i (
    .clk     (clk),
    .rstN    (rstN),
    .inValid (inValid),
    .inReady (inReady),
    .inInstr (inInstr),
    .inA     (inA),
    .inPc    (inPc),
    .lane    (laneReq)
  );

  // ========================================
  // Lanes
  // ========================================

  for (genvar i = 0; i < numLanes; i++)
  begin : gLane
    fcuLane #(
      .dataWid (dataWid),
      .addrMsb (addrMsb)
    ) lane_i (
      .clk      (clk),
      .rstN     (rstN),
      .req      (laneReq[i]),
      .ol       (ol),
      .im       (im),
      .tvec     (tvec),
      .waitCtr  (waitCtr),
      .rspValid (rspValid[i]),
      .rspReady (rspReady[i]),
      .rspBus   (rspBus[i])
    );
  end

  fcuCollect #(
    .numLanes (numLanes),
    .dataWid  (dataWid)
  ) collect_i (
    .clk      (clk),
    .rstN     (rstN),
    .rspValid (rspValid),
    .rspReady (rspReady),
    .rspBus   (rspBus),
    .outValid (outValid),
    .outReady (outReady),
    .outBus   (outBus)
  );

endmodule

// ==== verilog/fcuCollect.sv ====
// In-order collector for the flow-control lanes.
// Drains lane results in the same round-robin order the dispatcher used,
// so results leave the cluster in issue order.
module fcuCollect #(
  parameter int numLanes = 4,
  parameter int dataWid  = 64
) (
  input  logic                              clk,
  input  logic                              rstN,
  input  logic [numLanes-1:0]               rspValid,
  output logic [numLanes-1:0]               rspReady,
  input  logic [numLanes-1:0][dataWid-1:0]  rspBus,
  output logic                              outValid,
  input  logic                              outReady,
  output logic [dataWid-1:0]                outBus
);

  localparam int ptrWid = (numLanes > 1) ? $clog2(numLanes) : 1;

  logic [ptrWid-1:0] drainPtr;
  logic              outXfer;

  // ========================================
  // Output select
  // ========================================

  // Oldest result sits in the lane under the drain pointer
  assign outValid = rspValid[drainPtr];
  assign outBus   = rspBus[drainPtr];
  assign outXfer  = outValid && outReady;

  // Only the pointed lane may release its result
  always_comb
  begin
    rspReady = '0;
    rspReady[drainPtr] = outReady;
  end

  // ========================================
  // Drain pointer
  // ========================================

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      drainPtr <= '0;
    else if (outXfer)
    begin
      // Wrap after the last lane
      if (drainPtr == ptrWid'(numLanes - 1))
        drainPtr <= '0;
      else
        drainPtr <= drainPtr + 1'b1;
    end
  end

endmodule

// ==== verilog/fcuLane.sv ====
// One calculation lane of the flow-control cluster.
// Holds a single operation result, computed at acceptance. A new request
// is taken when the lane is empty or its result leaves on the same edge.
module fcuLane
  import fcuCfgPkg::*, fcuIsaPkg::*;
#(
  parameter int dataWid = 64,
  parameter int addrMsb = 31
) (
  input  logic               clk,
  input  logic               rstN,
  fcuReqIf.snk               req,
  input  opLevelE            ol,
  input  logic [3:0]         im,
  input  logic [dataWid-1:0] tvec,
  input  logic [dataWid-1:0] waitCtr,
  output logic               rspValid,
  input  logic               rspReady,
  output logic [dataWid-1:0] rspBus
);

  // PC step, wraps within the address width
  localparam logic [addrMsb:0] pcStep = instrBytes;

  logic               full;
  logic               accept;
  logic [addrMsb:0]   nextPc;
  logic [dataWid-1:0] calcBus;

  assign nextPc = req.pc + pcStep;

  fcuCalc #(
    .dataWid (dataWid),
    .addrMsb (addrMsb)
  ) calc_i (
    .ol      (ol),
    .instr   (req.instr),
    .tvec    (tvec),
    .a       (req.a),
    .pc      (req.pc),
    .nextPc  (nextPc),
    .im      (im),
    .waitCtr (waitCtr),
    .bus     (calcBus)
  );

  // Empty, or draining this cycle
  assign req.ready = !full || rspReady;
  assign accept    = req.valid && req.ready;
  assign rspValid  = full;

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      full <= 1'b0;
    else if (accept)
      full <= 1'b1;
    else if (rspReady)
      full <= 1'b0;
  end

  // Result payload
  always_ff @(posedge clk)
  begin
    if (accept)
      rspBus <= calcBus;
  end

endmodule

// ==== verilog/fcuCalc.sv ====
// Combinational flow-control result calculation.
// Decodes the opcode and sub-function of one instruction and forms the
// value put on the result bus: break code, counter update, link address,
// return target, exception vector or wait test.
module fcuCalc
  import fcuCfgPkg::*, fcuIsaPkg::*;
#(
  parameter int dataWid = 64,
  parameter int addrMsb = 31
) (
  input  opLevelE             ol,
  input  logic [instrWid-1:0] instr,
  input  logic [dataWid-1:0]  tvec,
  input  logic [dataWid-1:0]  a,
  // Address of the instruction itself
  input  logic [addrMsb:0]    pc,
  input  logic [addrMsb:0]    nextPc,
  input  logic [3:0]          im,
  input  logic [dataWid-1:0]  waitCtr,
  output logic [dataWid-1:0]  bus
);

  localparam int retOffWid = retLongMsb - retLongLsb + 1 + 3;

  logic [dataWid-1:0]   poison;
  opcodeE               opcode;
  bbcFuncE              bbcFunc;
  rtiFuncE              rtiFunc;
  logic [retOffWid-1:0] retOff;
  logic [3:0]           rexThresh;

  // ========================================
  // Field decode
  // ========================================

  assign poison  = {(dataWid / 8){poisonByte}};
  assign opcode  = opcodeE'(instr[opcodeMsb:opcodeLsb]);
  assign bbcFunc = bbcFuncE'(instr[bbcFuncMsb:bbcFuncLsb]);
  assign rtiFunc = rtiFuncE'(instr[rtiFuncMsb:rtiFuncLsb]);

  // Return offset in words, scaled to bytes
  assign retOff = (instr[retSizeMsb:retSizeLsb] == 2'b01) ?
                  {instr[retLongMsb:retLongLsb], 3'b000} :
                  retOffWid'({instr[retShortMsb:retShortLsb], 3'b000});

  // Interrupts below this mask level are taken by REX
  assign rexThresh = ~{ol, 2'b00};

  // ========================================
  // Result rule
  // ========================================

  always_comb
  begin
    case (opcode)
      // Break code from the operand or the immediate
      BRK:  bus = instr[brkSrcBit] ? dataWid'(a[7:0]) : dataWid'(instr[brkImmMsb:brkImmLsb]);
      BBC:
        case (bbcFunc)
          IBNE:    bus = a + dataWid'(1);
          DBNZ:    bus = a - dataWid'(1);
          default: bus = poison;
        endcase
      // Link address
      JAL:  bus = dataWid'(nextPc);
      CALL: bus = dataWid'(nextPc);
      RET:  bus = a + dataWid'(retOff);
      REX:
        // Not allowed from user level
        if (ol == USER)
          bus = poison;
        else
          bus = (im < rexThresh) ? tvec : dataWid'(nextPc);
      RTI:
        case (rtiFunc)
          WAIT:    bus = dataWid'(waitCtr == dataWid'(1));
          default: bus = poison;
        endcase
      default: bus = poison;
    endcase
  end

endmodule

// ==== verilog/fcuDispatch.sv ====
// Round-robin dispatcher for the flow-control lanes.
// Each accepted request goes to the lane under the issue pointer, and the
// pointer then moves on, so lanes are filled strictly in issue order.
module fcuDispatch
  import fcuCfgPkg::*;
#(
  parameter int numLanes = 4,
  parameter int dataWid  = 64,
  parameter int addrMsb  = 31
) (
  input  logic                clk,
  input  logic                rstN,
  input  logic                inValid,
  output logic                inReady,
  input  logic [instrWid-1:0] inInstr,
  input  logic [dataWid-1:0]  inA,
  input  logic [addrMsb:0]    inPc,
  fcuReqIf.src                lane [numLanes]
);

  localparam int ptrWid = (numLanes > 1) ? $clog2(numLanes) : 1;

  logic [ptrWid-1:0]   issuePtr;
  logic [numLanes-1:0] laneReady;
  logic                inXfer;

  // ========================================
  // Steering
  // ========================================

  for (genvar i = 0; i < numLanes; i++)
  begin : gSteer
    // Only the pointed lane sees valid, payload goes to all
    assign lane[i].valid = inValid && (issuePtr == ptrWid'(i));
    assign lane[i].instr = inInstr;
    assign lane[i].a     = inA;
    assign lane[i].pc    = inPc;
    // Collect readies so the pointer can select one
    assign laneReady[i]  = lane[i].ready;
  end

  // Ready of the lane that would take the next request
  assign inReady = laneReady[issuePtr];
  assign inXfer  = inValid && inReady;

  // ========================================
  // Issue pointer
  // ========================================

  // Advance modulo numLanes on every accepted request
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      issuePtr <= '0;
    else if (inXfer)
    begin
      if (issuePtr == ptrWid'(numLanes - 1))
        issuePtr <= '0;
      else
        issuePtr <= issuePtr + 1'b1;
    end
  end

endmodule

// ==== verilog/fcuReqIf.sv ====
// Request handshake between the dispatcher and one calculation lane.
// The dispatcher side uses the src modport, the lane side uses snk.
// A transfer happens on a rising edge with valid and ready both high.
interface fcuReqIf
  import fcuCfgPkg::*;
#(
  parameter int dataWid = 64,
  parameter int addrMsb = 31
) ();

  // Handshake pair
  logic                valid;
  logic                ready;

  // Operation payload, held stable while valid waits for ready
  logic [instrWid-1:0] instr;
  logic [dataWid-1:0]  a;
  logic [addrMsb:0]    pc;

  // Dispatcher side
  modport src (
    output valid,
    output instr,
    output a,
    output pc,
    input  ready
  );

  // Lane side
  modport snk (
    input  valid,
    input  instr,
    input  a,
    input  pc,
    output ready
  );

endinterface

// ==== verilog/fcuIsaPkg.sv ====
// Instruction set definitions for the flow-control cluster.
// Opcode, sub-function and operating-level enums, plus the bit positions
// of every instruction field that the calculation lanes decode.
package fcuIsaPkg;

  // ========================================
  // Enums
  // ========================================

  // Major opcode in bits 3..0, values 7..15 are illegal
  typedef enum logic [3:0] {
    BRK  = 4'd0,
    BBC  = 4'd1,
    JAL  = 4'd2,
    CALL = 4'd3,
    RET  = 4'd4,
    REX  = 4'd5,
    RTI  = 4'd6
  } opcodeE;

  // Branch-on-counter sub-function
  typedef enum logic [1:0] {
    IBNE = 2'd0,
    DBNZ = 2'd1
  } bbcFuncE;

  // Return-from-interrupt sub-function, only WAIT is defined
  typedef enum logic [4:0] {
    WAIT = 5'd1
  } rtiFuncE;

  // Privilege level of the core
  typedef enum logic [1:0] {
    USER    = 2'd0,
    SUPER   = 2'd1,
    HYPER   = 2'd2,
    MACHINE = 2'd3
  } opLevelE;

  // ========================================
  // Field positions
  // ========================================

  localparam int opcodeLsb   = 0;
  localparam int opcodeMsb   = 3;
  localparam int bbcFuncLsb  = 19;
  localparam int bbcFuncMsb  = 20;
  localparam int rtiFuncLsb  = 23;
  localparam int rtiFuncMsb  = 27;
  // BRK takes its code from a[7:0] when this bit is set
  localparam int brkSrcBit   = 16;
  localparam int brkImmLsb   = 8;
  localparam int brkImmMsb   = 15;
  // RET size select, 01 picks the long offset
  localparam int retSizeLsb  = 6;
  localparam int retSizeMsb  = 7;
  localparam int retLongLsb  = 23;
  localparam int retLongMsb  = 47;
  localparam int retShortLsb = 23;
  localparam int retShortMsb = 31;

endpackage

// ==== verilog/fcuCfgPkg.sv ====
// Cluster-wide constants for the flow-control cluster.
// Instruction geometry and the poison pattern for undefined results.
package fcuCfgPkg;

  // ========================================
  // Instruction geometry
  // ========================================

  // Every instruction is one 48-bit word
  localparam int instrWid = 48;

  // PC step from one instruction to the next
  localparam int instrBytes = 6;

  // ========================================
  // Result encodings
  // ========================================

  // Replicated across the data width for illegal or undefined results
  localparam logic [7:0] poisonByte = 8'hCC;

endpackage
